// ==== design/rv_isa_pkg.sv ====
/* RV32I instruction set definitions */

`default_nettype none

package rv_isa_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;     // data, address and instruction word
    typedef logic [4:0]      reg_addr_t;
    typedef logic [2:0]      funct3_t;

    // major opcodes kept by this core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_t;

    typedef enum logic [2:0] {
        TYPE_R,
        TYPE_I,
        TYPE_S,
        TYPE_B,
        TYPE_U,
        TYPE_J,
        TYPE_N  // unknown opcode, retires as no-op
    } inst_t;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } alu_op_t;

    // branch compares
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // load sizes
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    // store sizes
    localparam funct3_t F3_SB = 3'b000;
    localparam funct3_t F3_SH = 3'b001;
    localparam funct3_t F3_SW = 3'b010;

endpackage

`default_nettype wire

// ==== design/core_pkg.sv ====
/* core microarchitecture definitions */

`default_nettype none

package core_pkg;

    localparam rv_isa_pkg::word_t RESET_PC = 32'h8000_0000;

    typedef logic [3:0] strb_t;  // one bit per byte lane

    // one instruction in flight at a time
    typedef enum logic [1:0] {
        S_FETCH,
        S_IWAIT,
        S_EXEC,
        S_MEM
    } seq_state_t;

endpackage

`default_nettype wire

// ==== design/decode_if.sv ====
/* decoded instruction bundle */

`timescale 1ns/1ps
`default_nettype none

interface decode_if;

    rv_isa_pkg::opcode_t   opcode;
    rv_isa_pkg::funct3_t   funct3;
    rv_isa_pkg::reg_addr_t rd;
    rv_isa_pkg::reg_addr_t rs1;
    rv_isa_pkg::reg_addr_t rs2;
    rv_isa_pkg::word_t     imm;
    rv_isa_pkg::inst_t     inst_type;
    rv_isa_pkg::alu_op_t   alu_op;
    logic                  wb_en;   // instruction writes rd

    modport producer (output opcode, funct3, rd, rs1, rs2, imm, inst_type, alu_op, wb_en);
    modport consumer (input opcode, funct3, rd, rs1, rs2, imm, inst_type, alu_op, wb_en);

endinterface

`default_nettype wire

// ==== design/fetch_unit.sv ====
/* PC, instruction register and sequencer */

`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   jump_en,
    input  rv_isa_pkg::word_t      jump_target,
    input  logic                   is_mem,
    input  rv_isa_pkg::word_t      imem_rdata,
    output logic                   imem_req,
    output rv_isa_pkg::word_t      imem_addr,
    output rv_isa_pkg::word_t      pc,
    output rv_isa_pkg::word_t      snpc,
    output rv_isa_pkg::word_t      inst,
    output core_pkg::seq_state_t   state,
    output logic                   retire,
    output rv_isa_pkg::word_t      retire_pc
);

    core_pkg::seq_state_t next_state;
    rv_isa_pkg::word_t    dnpc;

    assign snpc = pc + 32'd4;
    assign dnpc = jump_en ? jump_target : snpc;

    assign imem_req  = (state == core_pkg::S_FETCH) && !reset;  // quiet while in reset
    assign imem_addr = pc;

    // loads and stores retire one cycle later, from S_MEM
    assign retire    = (state == core_pkg::S_EXEC && !is_mem) || (state == core_pkg::S_MEM);
    assign retire_pc = pc;

    always_comb begin
        case (state)
            core_pkg::S_FETCH: next_state = core_pkg::S_IWAIT;
            core_pkg::S_IWAIT: next_state = core_pkg::S_EXEC;
            core_pkg::S_EXEC:  next_state = is_mem ? core_pkg::S_MEM : core_pkg::S_FETCH;
            default:           next_state = core_pkg::S_FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= core_pkg::S_FETCH;
            pc    <= core_pkg::RESET_PC;
        end else begin
            state <= next_state;
            if (retire) pc <= dnpc;
        end
    end

    always_ff @(posedge clk) begin
        if (state == core_pkg::S_IWAIT) inst <= imem_rdata;  // word arrives in S_IWAIT
    end

    a_imem_req_single: assert property (@(posedge clk) disable iff (reset)
        imem_req |=> !imem_req)
        else $error("imem_req held for two cycles");

    a_fetch_after_retire: assert property (@(posedge clk) disable iff (reset)
        retire |=> imem_req)
        else $error("no fetch in the cycle after retire");

endmodule

`default_nettype wire

// ==== design/decode_unit.sv ====
/* instruction decoder */

`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input  rv_isa_pkg::word_t inst,
    decode_if.producer        dec
);

    logic [6:0] funct7;

    assign funct7     = inst[31:25];
    assign dec.opcode = rv_isa_pkg::opcode_t'(inst[6:0]);
    assign dec.funct3 = inst[14:12];
    assign dec.rd     = inst[11:7];
    assign dec.rs1    = inst[19:15];
    assign dec.rs2    = inst[24:20];

    always_comb begin
        case (dec.opcode)
            rv_isa_pkg::OP:     dec.inst_type = rv_isa_pkg::TYPE_R;
            rv_isa_pkg::OP_IMM,
            rv_isa_pkg::LOAD,
            rv_isa_pkg::JALR:   dec.inst_type = rv_isa_pkg::TYPE_I;
            rv_isa_pkg::STORE:  dec.inst_type = rv_isa_pkg::TYPE_S;
            rv_isa_pkg::BRANCH: dec.inst_type = rv_isa_pkg::TYPE_B;
            rv_isa_pkg::LUI,
            rv_isa_pkg::AUIPC:  dec.inst_type = rv_isa_pkg::TYPE_U;
            rv_isa_pkg::JAL:    dec.inst_type = rv_isa_pkg::TYPE_J;
            default:            dec.inst_type = rv_isa_pkg::TYPE_N;
        endcase
    end

    always_comb begin
        case (dec.inst_type)
            rv_isa_pkg::TYPE_I: dec.imm = {{20{inst[31]}}, inst[31:20]};
            rv_isa_pkg::TYPE_S: dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            rv_isa_pkg::TYPE_B: dec.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            rv_isa_pkg::TYPE_U: dec.imm = {inst[31:12], 12'b0};
            rv_isa_pkg::TYPE_J: dec.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:            dec.imm = '0;
        endcase
    end

    // everything other than OP/OP_IMM uses the adder
    always_comb begin
        dec.alu_op = rv_isa_pkg::ADD;
        if (dec.opcode == rv_isa_pkg::OP || dec.opcode == rv_isa_pkg::OP_IMM) begin
            case (dec.funct3)
                3'b000: begin
                    if (dec.opcode == rv_isa_pkg::OP && funct7[5]) dec.alu_op = rv_isa_pkg::SUB;
                end
                3'b001:  dec.alu_op = rv_isa_pkg::SLL;
                3'b010:  dec.alu_op = rv_isa_pkg::SLT;
                3'b011:  dec.alu_op = rv_isa_pkg::SLTU;
                3'b100:  dec.alu_op = rv_isa_pkg::XOR;
                3'b101:  dec.alu_op = funct7[5] ? rv_isa_pkg::SRA : rv_isa_pkg::SRL;
                3'b110:  dec.alu_op = rv_isa_pkg::OR;
                default: dec.alu_op = rv_isa_pkg::AND;
            endcase
        end
    end

    assign dec.wb_en = dec.inst_type inside {rv_isa_pkg::TYPE_R, rv_isa_pkg::TYPE_I,
                                             rv_isa_pkg::TYPE_U, rv_isa_pkg::TYPE_J};

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
/* integer register file */

`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  rv_isa_pkg::reg_addr_t waddr,
    input  rv_isa_pkg::reg_addr_t raddr1,
    input  rv_isa_pkg::reg_addr_t raddr2,
    input  rv_isa_pkg::word_t     wdata,
    output rv_isa_pkg::word_t     rdata1,
    output rv_isa_pkg::word_t     rdata2
);

    rv_isa_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // writer must never target x0
    a_x0_zero: assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
        else $error("x0 holds a nonzero value");

endmodule

`default_nettype wire

// ==== design/exec_unit.sv ====
/* ALU, branch compare and jump target */

`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  rv_isa_pkg::word_t pc,
    input  rv_isa_pkg::word_t snpc,
    input  rv_isa_pkg::word_t rdata1,
    input  rv_isa_pkg::word_t rdata2,
    decode_if.consumer        dec,
    output rv_isa_pkg::word_t alu_result,
    output logic              jump_en,
    output rv_isa_pkg::word_t jump_target,
    output rv_isa_pkg::word_t exec_data
);

    rv_isa_pkg::word_t alu_a;
    rv_isa_pkg::word_t alu_b;
    logic              taken;

    // operand select by format
    always_comb begin
        alu_a = rdata1;
        alu_b = rdata2;
        case (dec.inst_type)
            rv_isa_pkg::TYPE_I,
            rv_isa_pkg::TYPE_S: alu_b = dec.imm;
            rv_isa_pkg::TYPE_U: begin
                alu_a = (dec.opcode == rv_isa_pkg::LUI) ? '0 : pc;
                alu_b = dec.imm;
            end
            rv_isa_pkg::TYPE_J,
            rv_isa_pkg::TYPE_B: begin
                alu_a = pc;
                alu_b = dec.imm;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (dec.alu_op)
            rv_isa_pkg::SUB:  alu_result = alu_a - alu_b;
            rv_isa_pkg::SLL:  alu_result = alu_a << alu_b[4:0];
            rv_isa_pkg::SLT:  alu_result = rv_isa_pkg::word_t'($signed(alu_a) < $signed(alu_b));
            rv_isa_pkg::SLTU: alu_result = rv_isa_pkg::word_t'(alu_a < alu_b);
            rv_isa_pkg::XOR:  alu_result = alu_a ^ alu_b;
            rv_isa_pkg::SRL:  alu_result = alu_a >> alu_b[4:0];
            rv_isa_pkg::SRA:  alu_result = $signed(alu_a) >>> alu_b[4:0];
            rv_isa_pkg::OR:   alu_result = alu_a | alu_b;
            rv_isa_pkg::AND:  alu_result = alu_a & alu_b;
            default:          alu_result = alu_a + alu_b;
        endcase
    end

    // compares use the register pair, never the ALU operands
    always_comb begin
        case (dec.funct3)
            rv_isa_pkg::F3_BEQ:  taken = (rdata1 == rdata2);
            rv_isa_pkg::F3_BNE:  taken = (rdata1 != rdata2);
            rv_isa_pkg::F3_BLT:  taken = ($signed(rdata1) < $signed(rdata2));
            rv_isa_pkg::F3_BGE:  taken = ($signed(rdata1) >= $signed(rdata2));
            rv_isa_pkg::F3_BLTU: taken = (rdata1 < rdata2);
            rv_isa_pkg::F3_BGEU: taken = (rdata1 >= rdata2);
            default:             taken = 1'b0;
        endcase
    end

    always_comb begin
        jump_en     = 1'b0;
        jump_target = alu_result;
        if (dec.opcode == rv_isa_pkg::JALR) begin
            jump_en     = 1'b1;
            jump_target = {alu_result[31:1], 1'b0};  // bit 0 cleared
        end else if (dec.inst_type == rv_isa_pkg::TYPE_J) begin
            jump_en = 1'b1;
        end else if (dec.inst_type == rv_isa_pkg::TYPE_B) begin
            jump_en = taken;
        end
    end

    // link value for jumps
    assign exec_data = (dec.opcode == rv_isa_pkg::JAL || dec.opcode == rv_isa_pkg::JALR)
                     ? snpc : alu_result;

endmodule

`default_nettype wire

// ==== design/load_store_unit.sv ====
/* data memory access and write-back select */

`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  core_pkg::seq_state_t  state,
    input  rv_isa_pkg::word_t     alu_result,
    input  rv_isa_pkg::word_t     rdata2,
    input  rv_isa_pkg::word_t     exec_data,
    input  rv_isa_pkg::word_t     dmem_rdata,
    decode_if.consumer            dec,
    output logic                  is_mem,
    output logic                  dmem_req,
    output logic                  dmem_we,
    output core_pkg::strb_t       dmem_strb,
    output rv_isa_pkg::word_t     dmem_addr,
    output rv_isa_pkg::word_t     dmem_wdata,
    output rv_isa_pkg::word_t     wb_data,
    output logic                  wb_valid,
    output rv_isa_pkg::reg_addr_t wb_rd
);

    logic [1:0]        offset_q;    // byte offset held into S_MEM
    rv_isa_pkg::word_t shifted;
    rv_isa_pkg::word_t load_data;
    logic              retire_now;

    assign is_mem     = (dec.opcode == rv_isa_pkg::LOAD) || (dec.opcode == rv_isa_pkg::STORE);
    assign dmem_req   = is_mem && (state == core_pkg::S_EXEC);
    assign dmem_we    = (dec.opcode == rv_isa_pkg::STORE);
    assign dmem_addr  = {alu_result[31:2], 2'b00};

    // store data replicated over all lanes, strobe picks the bytes
    always_comb begin
        case (dec.funct3)
            rv_isa_pkg::F3_SB: begin
                dmem_wdata = {4{rdata2[7:0]}};
                dmem_strb  = core_pkg::strb_t'(4'b0001 << alu_result[1:0]);
            end
            rv_isa_pkg::F3_SH: begin
                dmem_wdata = {2{rdata2[15:0]}};
                dmem_strb  = core_pkg::strb_t'(4'b0011 << {alu_result[1], 1'b0});
            end
            default: begin
                dmem_wdata = rdata2;
                dmem_strb  = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) offset_q <= '0;
        else if (state == core_pkg::S_EXEC) offset_q <= alu_result[1:0];
    end

    assign shifted = dmem_rdata >> {offset_q, 3'b000};

    always_comb begin
        case (dec.funct3)
            rv_isa_pkg::F3_LB:  load_data = {{24{shifted[7]}}, shifted[7:0]};
            rv_isa_pkg::F3_LH:  load_data = {{16{shifted[15]}}, shifted[15:0]};
            rv_isa_pkg::F3_LBU: load_data = {24'b0, shifted[7:0]};
            rv_isa_pkg::F3_LHU: load_data = {16'b0, shifted[15:0]};
            default:            load_data = shifted;  // LW
        endcase
    end

    assign wb_data    = (dec.opcode == rv_isa_pkg::LOAD) ? load_data : exec_data;
    assign retire_now = (state == core_pkg::S_EXEC && !is_mem) || (state == core_pkg::S_MEM);
    assign wb_valid   = retire_now && dec.wb_en && (dec.rd != '0);
    assign wb_rd      = dec.rd;

    // the access always completes in the following S_MEM cycle
    a_dmem_req_exec: assert property (@(posedge clk) disable iff (reset)
        dmem_req |-> (state == core_pkg::S_EXEC) ##1 (state == core_pkg::S_MEM))
        else $error("dmem_req outside S_EXEC or not followed by S_MEM");

endmodule

`default_nettype wire

// ==== design/rv_core.sv ====
/* RV32I multi-cycle core */

`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic                  clk,
    input  logic                  reset,
    output logic                  imem_req,
    output rv_isa_pkg::word_t     imem_addr,
    input  rv_isa_pkg::word_t     imem_rdata,
    output logic                  dmem_req,
    output logic                  dmem_we,
    output core_pkg::strb_t       dmem_strb,
    output rv_isa_pkg::word_t     dmem_addr,
    output rv_isa_pkg::word_t     dmem_wdata,
    input  rv_isa_pkg::word_t     dmem_rdata,
    output logic                  retire,
    output rv_isa_pkg::word_t     retire_pc,
    output logic                  wb_valid,
    output rv_isa_pkg::reg_addr_t wb_rd,
    output rv_isa_pkg::word_t     wb_data
);

    rv_isa_pkg::word_t    pc;
    rv_isa_pkg::word_t    snpc;
    rv_isa_pkg::word_t    inst;
    core_pkg::seq_state_t state;
    logic                 jump_en;
    rv_isa_pkg::word_t    jump_target;
    logic                 is_mem;
    rv_isa_pkg::word_t    rdata1;
    rv_isa_pkg::word_t    rdata2;
    rv_isa_pkg::word_t    alu_result;
    rv_isa_pkg::word_t    exec_data;   // ALU result or link value

    decode_if u_dec_bus ();

    fetch_unit u_fetch (
        .clk         (clk),
        .reset       (reset),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .is_mem      (is_mem),
        .imem_rdata  (imem_rdata),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .pc          (pc),
        .snpc        (snpc),
        .inst        (inst),
        .state       (state),
        .retire      (retire),
        .retire_pc   (retire_pc)
    );

    decode_unit u_decode (
        .inst (inst),
        .dec  (u_dec_bus)
    );

    reg_file u_regs (
        .clk    (clk),
        .reset  (reset),
        .we     (wb_valid),
        .waddr  (wb_rd),
        .raddr1 (u_dec_bus.rs1),
        .raddr2 (u_dec_bus.rs2),
        .wdata  (wb_data),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    exec_unit u_exec (
        .pc          (pc),
        .snpc        (snpc),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .dec         (u_dec_bus),
        .alu_result  (alu_result),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .exec_data   (exec_data)
    );

    load_store_unit u_lsu (
        .clk        (clk),
        .reset      (reset),
        .state      (state),
        .alu_result (alu_result),
        .rdata2     (rdata2),
        .exec_data  (exec_data),
        .dmem_rdata (dmem_rdata),
        .dec        (u_dec_bus),
        .is_mem     (is_mem),
        .dmem_req   (dmem_req),
        .dmem_we    (dmem_we),
        .dmem_strb  (dmem_strb),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .wb_data    (wb_data),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd)
    );

endmodule

`default_nettype wire

// ==== dv/tb_rv_core.sv ====
/* rv_core testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam int PROG_LEN  = 57;
    localparam int MAX_STEPS = 64;
    localparam int LIMIT     = 4 * PROG_LEN + 20;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  imem_req;
    rv_isa_pkg::word_t     imem_addr;
    rv_isa_pkg::word_t     imem_rdata;
    logic                  dmem_req;
    logic                  dmem_we;
    core_pkg::strb_t       dmem_strb;
    rv_isa_pkg::word_t     dmem_addr;
    rv_isa_pkg::word_t     dmem_wdata;
    rv_isa_pkg::word_t     dmem_rdata;
    logic                  retire;
    rv_isa_pkg::word_t     retire_pc;
    logic                  wb_valid;
    rv_isa_pkg::reg_addr_t wb_rd;
    rv_isa_pkg::word_t     wb_data;

    rv_isa_pkg::word_t     prog [MAX_STEPS];
    rv_isa_pkg::word_t     imem_off;    // byte offset into the program table
    rv_isa_pkg::word_t     dmem [16];
    rv_isa_pkg::word_t     init_mem [16];
    rv_isa_pkg::word_t     exp_mem [16];

    // expected retire table
    rv_isa_pkg::word_t     exp_pc [MAX_STEPS];
    logic                  exp_valid [MAX_STEPS];
    rv_isa_pkg::reg_addr_t exp_rd [MAX_STEPS];
    rv_isa_pkg::word_t     exp_data [MAX_STEPS];
    logic                  exp_is_mem [MAX_STEPS];
    int                    n_exp;
    int                    cyc;
    int                    req_cyc;

    rv_core u_rv_core (
        .clk(clk), .reset(reset),
        .imem_req(imem_req), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .dmem_req(dmem_req), .dmem_we(dmem_we), .dmem_strb(dmem_strb),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata),
        .retire(retire), .retire_pc(retire_pc),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    task automatic check_word(input string name, input rv_isa_pkg::word_t got,
                              input rv_isa_pkg::word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_reg(input string name, input rv_isa_pkg::reg_addr_t got,
                             input rv_isa_pkg::reg_addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%02h expected 0x%02h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    // instruction encoders
    function automatic rv_isa_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP};
    endfunction

    function automatic rv_isa_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_isa_pkg::word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_isa_pkg::STORE};
    endfunction

    function automatic rv_isa_pkg::word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::BRANCH};
    endfunction

    function automatic rv_isa_pkg::word_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
            input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic rv_isa_pkg::word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::JAL};
    endfunction

    function automatic rv_isa_pkg::word_t slot_pc(input int slot);
        return core_pkg::RESET_PC + rv_isa_pkg::word_t'(4 * slot);
    endfunction

    // place an instruction and append its expected retire
    task automatic add_step(input int slot, input rv_isa_pkg::word_t word, input logic valid,
            input rv_isa_pkg::reg_addr_t rd, input rv_isa_pkg::word_t data, input logic mem);
        prog[slot]        = word;
        exp_pc[n_exp]     = slot_pc(slot);
        exp_valid[n_exp]  = valid;
        exp_rd[n_exp]     = rd;
        exp_data[n_exp]   = data;
        exp_is_mem[n_exp] = mem;
        n_exp++;
    endtask

    // taken branch skips a poison slot, then a not-taken one falls through
    task automatic add_branch_pair(input int slot, input logic [2:0] f3,
            input logic [4:0] t_a, input logic [4:0] t_b,
            input logic [4:0] n_a, input logic [4:0] n_b);
        add_step(slot, enc_b(13'd8, t_b, t_a, f3), 1'b0, 5'd0, '0, 1'b0);
        prog[slot + 1] = enc_i(12'd1, 5'd0, 3'b000, 5'd31, rv_isa_pkg::OP_IMM);
        add_step(slot + 2, enc_b(13'd8, n_b, n_a, f3), 1'b0, 5'd0, '0, 1'b0);
    endtask

    task automatic build_program();
        logic [6:0] opi;
        logic [6:0] ld;
        opi = rv_isa_pkg::OP_IMM;
        ld  = rv_isa_pkg::LOAD;
        for (int i = 0; i < MAX_STEPS; i++) prog[i] = 32'h0000_0013;  // nop
        n_exp = 0;
        add_step(0, enc_i(-12'sd5, 5'd0, 3'b000, 5'd1, opi), 1'b1, 5'd1, 32'hFFFF_FFFB, 1'b0);
        add_step(1, enc_i(12'd3, 5'd0, 3'b000, 5'd2, opi), 1'b1, 5'd2, 32'd3, 1'b0);
        add_step(2, enc_u(20'h12345, 5'd3, rv_isa_pkg::LUI), 1'b1, 5'd3, 32'h1234_5000, 1'b0);
        add_step(3, enc_u(20'h00001, 5'd4, rv_isa_pkg::AUIPC), 1'b1, 5'd4, 32'h8000_100C, 1'b0);
        add_step(4, enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd5), 1'b1, 5'd5, 32'hFFFF_FFFE, 1'b0);
        add_step(5, enc_r(7'h20, 5'd1, 5'd2, 3'b000, 5'd6), 1'b1, 5'd6, 32'd8, 1'b0);
        add_step(6, enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd7), 1'b1, 5'd7, 32'hFFFF_FFD8, 1'b0);
        add_step(7, enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd8), 1'b1, 5'd8, 32'd1, 1'b0);
        add_step(8, enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd9), 1'b1, 5'd9, 32'd0, 1'b0);
        add_step(9, enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd10), 1'b1, 5'd10, 32'hFFFF_FFF8, 1'b0);
        add_step(10, enc_r(7'h00, 5'd2, 5'd1, 3'b101, 5'd11), 1'b1, 5'd11, 32'h1FFF_FFFF, 1'b0);
        add_step(11, enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd12), 1'b1, 5'd12, 32'hFFFF_FFFF, 1'b0);
        add_step(12, enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd13), 1'b1, 5'd13, 32'hFFFF_FFFB, 1'b0);
        add_step(13, enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd14), 1'b1, 5'd14, 32'd3, 1'b0);
        add_step(14, enc_i(12'd7, 5'd0, 3'b000, 5'd0, opi), 1'b0, 5'd0, '0, 1'b0);  // to x0
        add_step(15, enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd15), 1'b1, 5'd15, 32'd0, 1'b0);
        // x1 = -5, x2 = 3
        add_branch_pair(16, rv_isa_pkg::F3_BEQ,  5'd2, 5'd2, 5'd1, 5'd2);
        add_branch_pair(19, rv_isa_pkg::F3_BNE,  5'd1, 5'd2, 5'd2, 5'd2);
        add_branch_pair(22, rv_isa_pkg::F3_BLT,  5'd1, 5'd2, 5'd2, 5'd1);
        add_branch_pair(25, rv_isa_pkg::F3_BGE,  5'd2, 5'd1, 5'd1, 5'd2);
        add_branch_pair(28, rv_isa_pkg::F3_BLTU, 5'd2, 5'd1, 5'd1, 5'd2);
        add_branch_pair(31, rv_isa_pkg::F3_BGEU, 5'd1, 5'd2, 5'd2, 5'd1);
        add_step(34, enc_j(21'd8, 5'd16), 1'b1, 5'd16, slot_pc(35), 1'b0);
        prog[35] = enc_i(12'd1, 5'd0, 3'b000, 5'd31, opi);
        add_step(36, enc_u(20'h0, 5'd17, rv_isa_pkg::AUIPC), 1'b1, 5'd17, slot_pc(36), 1'b0);
        add_step(37, enc_i(12'd13, 5'd17, 3'b000, 5'd18, rv_isa_pkg::JALR),
                 1'b1, 5'd18, slot_pc(38), 1'b0);
        prog[38] = enc_i(12'd1, 5'd0, 3'b000, 5'd31, opi);
        add_step(39, enc_u(20'h87654, 5'd19, rv_isa_pkg::LUI), 1'b1, 5'd19, 32'h8765_4000, 1'b0);
        add_step(40, enc_i(12'h321, 5'd19, 3'b000, 5'd19, opi), 1'b1, 5'd19, 32'h8765_4321, 1'b0);
        add_step(41, enc_s(12'd0, 5'd19, 5'd0, rv_isa_pkg::F3_SW), 1'b0, 5'd0, '0, 1'b1);
        add_step(42, enc_s(12'd4, 5'd19, 5'd0, rv_isa_pkg::F3_SB), 1'b0, 5'd0, '0, 1'b1);
        add_step(43, enc_s(12'd9, 5'd19, 5'd0, rv_isa_pkg::F3_SB), 1'b0, 5'd0, '0, 1'b1);
        add_step(44, enc_s(12'd14, 5'd19, 5'd0, rv_isa_pkg::F3_SB), 1'b0, 5'd0, '0, 1'b1);
        add_step(45, enc_s(12'd19, 5'd19, 5'd0, rv_isa_pkg::F3_SB), 1'b0, 5'd0, '0, 1'b1);
        add_step(46, enc_s(12'd20, 5'd19, 5'd0, rv_isa_pkg::F3_SH), 1'b0, 5'd0, '0, 1'b1);
        add_step(47, enc_s(12'd26, 5'd19, 5'd0, rv_isa_pkg::F3_SH), 1'b0, 5'd0, '0, 1'b1);
        add_step(48, enc_i(12'd0, 5'd0, rv_isa_pkg::F3_LW, 5'd20, ld),
                 1'b1, 5'd20, 32'h8765_4321, 1'b1);
        add_step(49, enc_i(12'd3, 5'd0, rv_isa_pkg::F3_LB, 5'd21, ld),
                 1'b1, 5'd21, 32'hFFFF_FF87, 1'b1);
        add_step(50, enc_i(12'd3, 5'd0, rv_isa_pkg::F3_LBU, 5'd22, ld),
                 1'b1, 5'd22, 32'h87, 1'b1);
        add_step(51, enc_i(12'd2, 5'd0, rv_isa_pkg::F3_LH, 5'd23, ld),
                 1'b1, 5'd23, 32'hFFFF_8765, 1'b1);
        add_step(52, enc_i(12'd2, 5'd0, rv_isa_pkg::F3_LHU, 5'd24, ld),
                 1'b1, 5'd24, 32'h8765, 1'b1);
        add_step(53, enc_i(12'd0, 5'd0, rv_isa_pkg::F3_LB, 5'd25, ld),
                 1'b1, 5'd25, 32'h21, 1'b1);
        add_step(54, enc_i(12'd0, 5'd0, rv_isa_pkg::F3_LH, 5'd26, ld),
                 1'b1, 5'd26, 32'h4321, 1'b1);
        add_step(55, enc_i(12'd4, 5'd0, rv_isa_pkg::F3_LB, 5'd27, ld),
                 1'b1, 5'd27, 32'h21, 1'b1);
        add_step(56, enc_i(12'd26, 5'd0, rv_isa_pkg::F3_LH, 5'd28, ld),
                 1'b1, 5'd28, 32'h4321, 1'b1);
    endtask

    assign imem_off = imem_addr - core_pkg::RESET_PC;

    // instruction and data memory models, one cycle latency
    always @(posedge clk) begin
        if (imem_req) begin
            if (imem_off < rv_isa_pkg::word_t'(4 * MAX_STEPS))
                imem_rdata <= prog[imem_off[7:2]];
            else
                imem_rdata <= 32'h0000_0013;
        end
        if (dmem_req) begin
            if (dmem_we) begin
                for (int b = 0; b < 4; b++) begin
                    if (dmem_strb[b]) dmem[dmem_addr[5:2]][8*b +: 8] = dmem_wdata[8*b +: 8];
                end
            end else begin
                dmem_rdata <= dmem[dmem_addr[5:2]];
            end
        end
    end

    always @(posedge clk) begin
        if (reset) cyc <= 0;
        else cyc <= cyc + 1;
        if (cyc > LIMIT) begin
            $display("timeout: program did not retire all instructions in %0d cycles", LIMIT);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    end

    always @(negedge clk) begin
        if (wb_valid && !retire) begin
            $display("wb_valid seen without retire");
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
        if (reset) begin
            check_bit("imem_req", imem_req, 1'b0);
            check_bit("retire", retire, 1'b0);
            check_bit("wb_valid", wb_valid, 1'b0);
            check_bit("dmem_req", dmem_req, 1'b0);
        end
    end

    initial begin
        reset      = 1'b1;
        imem_rdata = '0;
        dmem_rdata = '0;
        cyc        = 0;
        req_cyc    = 0;
        void'($urandom(32'h8c8b3c92));
        for (int i = 0; i < 16; i++) begin
            dmem[i]     = $urandom;
            init_mem[i] = dmem[i];
        end
        build_program();

        repeat (3) @(posedge clk);
        reset <= 1'b0;

        for (int k = 0; k < n_exp; k++) begin
            @(negedge clk);
            check_bit("imem_req", imem_req, 1'b1);  // due right out of reset and after each retire
            check_word("imem_addr", imem_addr, exp_pc[k]);
            req_cyc = cyc;
            @(negedge clk);
            while (!retire) @(negedge clk);
            check_word("retire_latency", cyc - req_cyc, exp_is_mem[k] ? 3 : 2);
            check_word("retire_pc", retire_pc, exp_pc[k]);
            check_bit("wb_valid", wb_valid, exp_valid[k]);
            if (exp_valid[k]) begin
                check_reg("wb_rd", wb_rd, exp_rd[k]);
                check_word("wb_data", wb_data, exp_data[k]);
            end
        end

        // stores change only the addressed bytes
        for (int i = 0; i < 16; i++) exp_mem[i] = init_mem[i];
        exp_mem[0]        = 32'h8765_4321;
        exp_mem[1][7:0]   = 8'h21;
        exp_mem[2][15:8]  = 8'h21;
        exp_mem[3][23:16] = 8'h21;
        exp_mem[4][31:24] = 8'h21;
        exp_mem[5][15:0]  = 16'h4321;
        exp_mem[6][31:16] = 16'h4321;
        for (int i = 0; i < 16; i++) check_word($sformatf("dmem[%0d]", i), dmem[i], exp_mem[i]);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
design/rv_isa_pkg.sv
design/core_pkg.sv
design/decode_if.sv
design/fetch_unit.sv
design/decode_unit.sv
design/reg_file.sv
design/exec_unit.sv
design/load_store_unit.sv
design/rv_core.sv
dv/tb_rv_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_rv_core \
    --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
fi
exit 1
